// File: filelist.f
rtl/qspi_bridge_pkg.sv
rtl/qspi_read_info_fifo.sv
rtl/qspi_cmd_arbiter.sv
rtl/qspi_write_agent.sv
rtl/qspi_read_agent.sv
rtl/qspi_axi_bridge.sv
tb/tb_clock_gen.sv
tb/qspi_ctrl_stub.sv
tb/tb_qspi_axi_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run; status follows the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_qspi_axi_bridge \
	-f filelist.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -qF '*** PASSED ***' \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }

// File: tb/tb_qspi_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qspi_axi_bridge;

	localparam int N_TXN          = 74;
	localparam int CYCLES_PER_TXN = 300;

	logic clock, rst_n;
	qspi_bridge_pkg::axi_addr_t aw, ar;
	qspi_bridge_pkg::axi_w_t w;
	qspi_bridge_pkg::axi_b_t b;
	qspi_bridge_pkg::axi_r_t r;
	qspi_bridge_pkg::flash_cmd_t cmd;
	logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
	logic ar_valid, ar_ready, r_valid, r_ready, cmd_valid, cmd_ready;
	logic tdata_wen, tdata_full, tdata_lock, tdata_key;
	logic [31:0] tdata_wdata, rdata_rdata;
	logic rdata_ren, rdata_empty, tran_inst_label;

	integer seed = 32'he09a73c0;
	int errors = 0;
	int test_no = 0;
	int err_base = 0;
	bit stim_started = 0;
	bit in_write = 0; // AW taken and B still open
	bit first_beat = 0;
	bit tx_locked = 0;
	bit label_seen = 0;
	qspi_bridge_pkg::axi_addr_t aw_hold;

	qspi_bridge_pkg::flash_cmd_t exp_cmd[$];
	logic [31:0] exp_word[$];
	bit exp_key[$];
	qspi_bridge_pkg::axi_b_t exp_b[$];
	qspi_bridge_pkg::axi_r_t exp_r[$];

	tb_clock_gen i_tb_clock_gen (.clock(clock), .rst_n(rst_n));

	qspi_ctrl_stub i_qspi_ctrl_stub (.*);

	qspi_axi_bridge i_qspi_axi_bridge (.*);

	task automatic fail_note(input string msg);
		$display("%0t: %s", $time, msg);
		errors++;
	endtask

	task automatic check_cmd(input qspi_bridge_pkg::flash_cmd_t got,
		input qspi_bridge_pkg::flash_cmd_t exp);
		if (got !== exp) begin
			$display("ERR %0t: command %h, expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t: transmit word %h, expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_b(input qspi_bridge_pkg::axi_b_t got,
		input qspi_bridge_pkg::axi_b_t exp);
		if (got !== exp) begin
			$display("ERR %0t: B %h, expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_r(input qspi_bridge_pkg::axi_r_t got,
		input qspi_bridge_pkg::axi_r_t exp);
		if (got !== exp) begin
			$display("ERR %0t: R %h, expected %h", $time, got, exp);
			errors++;
		end
	endtask

	function automatic logic [2:0] lowest_strobe(input logic [7:0] strb);
		logic [2:0] idx;
		logic found;
		idx = 3'd0;
		found = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (strb[i] && !found) begin
				idx = 3'(i);
				found = 1'b1;
			end
		end
		return idx;
	endfunction

	function automatic qspi_bridge_pkg::flash_cmd_t model_cmd(input logic [7:0] inst,
		input logic [23:0] addr, input logic [7:0] len, input logic [2:0] size);
		qspi_bridge_pkg::flash_cmd_t c;
		c.inst = inst;
		c.addr = addr;
		c.data_size = (size == 3'd0) ? 8'd2 : (size == 3'd1) ? 8'd4 : 8'd8;
		if (len != 8'd0)
			c.burstlen = 8'((int'(len) + 1) * 2);
		else
			c.burstlen = (size == 3'd3) ? 8'd2 : 8'd1;
		return c;
	endfunction

	// Words the controller stub returns for a read at addr
	function automatic logic [31:0] stub_word(input logic [23:0] addr, input int j);
		return {8'hA5, addr + 24'(j)};
	endfunction

	task automatic expect_beat(input qspi_bridge_pkg::axi_w_t wb, input logic [2:0] size);
		int lo;
		logic [31:0] lane;
		lo = int'(lowest_strobe(wb.strb));
		if (size == 3'd3) begin
			exp_word.push_back(wb.data[31:0]);
			exp_key.push_back(1'b0);
			exp_word.push_back(wb.data[63:32]);
			exp_key.push_back(wb.last);
		end else begin
			case (size)
				3'd0:    lane = {4{wb.data[8*lo +: 8]}};
				3'd1:    lane = {2{wb.data[16*(lo/2) +: 16]}};
				default: lane = wb.data[32*(lo/4) +: 32];
			endcase
			exp_word.push_back(lane);
			exp_key.push_back(wb.last);
		end
	endtask

	task automatic expect_read(input qspi_bridge_pkg::axi_addr_t a);
		qspi_bridge_pkg::axi_r_t e;
		logic [31:0] w0, w1;
		for (int k = 0; k <= int'(a.len); k++) begin
			w0 = stub_word(a.addr, 2 * k);
			w1 = stub_word(a.addr, 2 * k + 1);
			e.id   = a.id;
			e.resp = 2'b00;
			e.last = k == int'(a.len);
			case (a.size)
				3'd0:    e.data = {8{w0[31:24]}};
				3'd1:    e.data = {4{w0[31:16]}};
				3'd2:    e.data = {2{w0}};
				default: e.data = {w1, w0};
			endcase
			exp_r.push_back(e);
		end
	endtask

	always @(posedge clock) begin : monitor
		qspi_bridge_pkg::flash_cmd_t ec;
		bit k;
		if (rst_n) begin
			if (!stim_started && (cmd_valid | tdata_wen | tdata_lock | tdata_key | b_valid
				| r_valid | rdata_ren))
				fail_note("an output strobe or valid was active before stimulus");
			if (b_valid && b_ready) begin
				if (exp_b.size() == 0)
					fail_note("B response with no completed write");
				else
					check_b(b, exp_b.pop_front());
				in_write = 0;
			end
			// Read taken in the first-beat cycle comes ahead of the write
			if (ar_valid && ar_ready) begin
				exp_cmd.push_back(model_cmd(qspi_bridge_pkg::INST_FRQIO, ar.addr, ar.len,
					ar.size));
				expect_read(ar);
			end
			if (aw_valid && aw_ready) begin
				if (in_write)
					fail_note("AW accepted before the previous B completed");
				in_write = 1;
				aw_hold = aw;
				first_beat = 1;
			end
			if (w_valid && w_ready) begin
				if (first_beat)
					exp_cmd.push_back(model_cmd(qspi_bridge_pkg::INST_PP,
						{aw_hold.addr[23:3], lowest_strobe(w.strb)}, aw_hold.len, aw_hold.size));
				first_beat = 0;
				expect_beat(w, aw_hold.size);
			end
			if (cmd_valid && cmd_ready) begin
				if (exp_cmd.size() == 0) begin
					fail_note("command issued with none expected");
				end else begin
					ec = exp_cmd.pop_front();
					check_cmd(cmd, ec);
					if (tdata_lock != (ec.inst == qspi_bridge_pkg::INST_PP))
						fail_note("lock pulse does not match the command transfer");
					if (tdata_lock)
						tx_locked = 1;
				end
			end else if (tdata_lock) begin
				fail_note("lock pulse without a command transfer");
			end
			if (tdata_wen) begin
				if (!tx_locked)
					fail_note("transmit word pushed before lock");
				if (tdata_full)
					fail_note("transmit word pushed while the FIFO was full");
				if (exp_word.size() == 0) begin
					fail_note("transmit word with none expected");
				end else begin
					check_word(tdata_wdata, exp_word.pop_front());
					k = exp_key.pop_front();
					if (tdata_key != k)
						fail_note("key pulse not on the final word");
					if (k) begin
						tx_locked = 0;
						exp_b.push_back({aw_hold.id, 2'b00});
					end
				end
			end else if (tdata_key) begin
				fail_note("key pulse without a push");
			end
			if (r_valid && r_ready) begin
				if (exp_r.size() == 0)
					fail_note("R beat with none expected");
				else
					check_r(r, exp_r.pop_front());
			end
			if (rdata_ren && (!label_seen || rdata_empty))
				fail_note("receive pop while the label was low or the FIFO empty");
			label_seen = tran_inst_label;
		end
	end

	always @(negedge clock) begin
		if (stim_started) begin
			b_ready = ($unsigned($random(seed)) % 4) != 0;
			r_ready = ($unsigned($random(seed)) % 10) < 7;
		end
	end

	task automatic pick_shape(input bit wide_ok, output logic [2:0] size,
		output logic [7:0] len);
		if (wide_ok && $random(seed) % 2 == 0) begin
			size = 3'd3;
			len  = 8'($unsigned($random(seed)) % 8);
		end else begin
			size = 3'($unsigned($random(seed)) % 3);
			len  = 8'd0; // Narrow bursts stay single beat
		end
	endtask

	task automatic send_write(input logic [2:0] size, input logic [7:0] len);
		@(negedge clock);
		aw.id    = 4'($random(seed));
		aw.addr  = 24'($random(seed));
		aw.len   = len;
		aw.size  = size;
		aw_valid = 1'b1;
		@(posedge clock);
		while (!aw_ready)
			@(posedge clock);
		@(negedge clock);
		aw_valid = 1'b0;
		for (int k = 0; k <= int'(len); k++) begin
			w.data  = {$random(seed), $random(seed)};
			w.strb  = 8'($random(seed));
			w.last  = k == int'(len);
			w_valid = 1'b1;
			@(posedge clock);
			while (!w_ready)
				@(posedge clock);
			@(negedge clock);
			w_valid = 1'b0;
		end
	endtask

	task automatic send_read(input logic [2:0] size, input logic [7:0] len);
		@(negedge clock);
		ar.id    = 4'($random(seed));
		ar.addr  = 24'($random(seed));
		ar.len   = len;
		ar.size  = size;
		ar_valid = 1'b1;
		@(posedge clock);
		while (!ar_ready)
			@(posedge clock);
		@(negedge clock);
		ar_valid = 1'b0;
	endtask

	task automatic drain_and_report(input string name);
		do
			@(posedge clock);
		while (exp_cmd.size() != 0 || exp_word.size() != 0 || exp_b.size() != 0
			|| exp_r.size() != 0 || in_write);
		repeat (5) @(posedge clock);
		test_no++;
		$display("test %0d %s: %0d errors", test_no, name, errors - err_base);
		err_base = errors;
	endtask

	initial begin : stimulus
		logic [2:0] sz;
		logic [7:0] ln;
		aw = '0;
		w = '0;
		ar = '0;
		aw_valid = 1'b0;
		w_valid = 1'b0;
		ar_valid = 1'b0;
		b_ready = 1'b0;
		r_ready = 1'b0;
		@(posedge rst_n);
		repeat (6) @(posedge clock); // Outputs must stay quiet here
		stim_started = 1;

		repeat (12) begin
			pick_shape(0, sz, ln);
			send_write(sz, ln);
		end
		drain_and_report("narrow single-beat writes");
		repeat (8) send_write(3'd3, 8'($unsigned($random(seed)) % 8));
		drain_and_report("full-width write bursts");
		for (int i = 0; i < 12; i++)
			send_read(3'(i % 4), 8'd0);
		drain_and_report("single-beat reads");
		repeat (16) send_read(3'd3, 8'($unsigned($random(seed)) % 8));
		drain_and_report("read bursts");
		fork
			repeat (10) begin : writer
				logic [2:0] wsz;
				logic [7:0] wln;
				pick_shape(1, wsz, wln);
				send_write(wsz, wln);
			end
			repeat (16) begin : reader
				logic [2:0] rsz;
				logic [7:0] rln;
				pick_shape(1, rsz, rln);
				send_read(rsz, rln);
			end
		join
		drain_and_report("mixed traffic");

		$display("tests: %0d, errors: %0d", test_no, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial begin : watchdog
		#(N_TXN * CYCLES_PER_TXN * 10 + 1000);
		$display("timeout: transactions did not complete in the allowed time");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/qspi_ctrl_stub.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_ctrl_stub #(
	parameter logic [31:0] SEED = 32'he09a73c0
) (
	input  wire                               clock,
	input  wire                               rst_n,
	input  wire qspi_bridge_pkg::flash_cmd_t  cmd,
	input  wire                               cmd_valid,
	output logic                              cmd_ready,
	output logic                              tdata_full,
	input  wire                               rdata_ren,
	output logic [31:0]                       rdata_rdata,
	output logic                              rdata_empty,
	output logic                              tran_inst_label
);

	integer seed;
	logic [31:0] rx_q[$]; // Words waiting in the receive FIFO

	initial begin
		seed            = SEED;
		cmd_ready       = 1'b0;
		tdata_full      = 1'b0;
		rdata_rdata     = '0;
		rdata_empty     = 1'b1;
		tran_inst_label = 1'b0;
	end

	always @(posedge clock) begin : take
		if (rst_n) begin
			if (cmd_valid && cmd_ready) begin
				// Quad read fills the receive side
				if (cmd.inst == qspi_bridge_pkg::INST_FRQIO)
					for (int j = 0; j < int'(cmd.burstlen); j++)
						rx_q.push_back({8'hA5, cmd.addr + 24'(j)});
			end
			if (rdata_ren && rx_q.size() != 0)
				void'(rx_q.pop_front());
		end
	end

	always @(negedge clock) begin
		if (!rst_n) begin
			cmd_ready       = 1'b0;
			tdata_full      = 1'b0;
			tran_inst_label = 1'b0;
		end else begin
			cmd_ready       = ($unsigned($random(seed)) % 4) != 0;
			tdata_full      = ($unsigned($random(seed)) % 4) == 0;
			tran_inst_label = ($unsigned($random(seed)) % 10) != 0; // Occasional drop
		end
		rdata_empty = rx_q.size() == 0;
		rdata_rdata = rdata_empty ? 32'h0 : rx_q[0];
	end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 5,
	parameter int RESET_CYCLES = 16
) (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1; // Release away from the active edge
	end

endmodule

`default_nettype wire

// File: rtl/qspi_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_axi_bridge (
	input  wire                                     clock,
	input  wire                                     rst_n,
	input  wire qspi_bridge_pkg::axi_addr_t         aw,
	input  wire                                     aw_valid,
	output logic                                    aw_ready,
	input  wire qspi_bridge_pkg::axi_w_t            w,
	input  wire                                     w_valid,
	output logic                                    w_ready,
	output qspi_bridge_pkg::axi_b_t                 b,
	output logic                                    b_valid,
	input  wire                                     b_ready,
	input  wire qspi_bridge_pkg::axi_addr_t         ar,
	input  wire                                     ar_valid,
	output logic                                    ar_ready,
	output qspi_bridge_pkg::axi_r_t                 r,
	output logic                                    r_valid,
	input  wire                                     r_ready,
	output qspi_bridge_pkg::flash_cmd_t             cmd,
	output logic                                    cmd_valid,
	input  wire                                     cmd_ready,
	output logic                                    tdata_wen,
	output logic [qspi_bridge_pkg::WORD_WIDTH-1:0]  tdata_wdata,
	input  wire                                     tdata_full,
	output logic                                    tdata_lock,
	output logic                                    tdata_key,
	output logic                                    rdata_ren,
	input  wire [qspi_bridge_pkg::WORD_WIDTH-1:0]   rdata_rdata,
	input  wire                                     rdata_empty,
	input  wire                                     tran_inst_label
);

	qspi_bridge_pkg::flash_cmd_t wr_cmd;
	qspi_bridge_pkg::flash_cmd_t rd_cmd;
	logic wr_req, wr_grant;
	logic rd_req, rd_grant;
	logic cmd_sent, cmd_free;
	logic wr_pending; // Write side claims this cycle

	qspi_write_agent i_qspi_write_agent (
		.clock       (clock),
		.rst_n       (rst_n),
		.aw          (aw),
		.aw_valid    (aw_valid),
		.aw_ready    (aw_ready),
		.w           (w),
		.w_valid     (w_valid),
		.w_ready     (w_ready),
		.b           (b),
		.b_valid     (b_valid),
		.b_ready     (b_ready),
		.wr_req      (wr_req),
		.wr_cmd      (wr_cmd),
		.wr_grant    (wr_grant),
		.cmd_sent    (cmd_sent),
		.wr_pending  (wr_pending),
		.tdata_wen   (tdata_wen),
		.tdata_wdata (tdata_wdata),
		.tdata_full  (tdata_full),
		.tdata_lock  (tdata_lock),
		.tdata_key   (tdata_key)
	);

	qspi_read_agent i_qspi_read_agent (
		.clock           (clock),
		.rst_n           (rst_n),
		.ar              (ar),
		.ar_valid        (ar_valid),
		.ar_ready        (ar_ready),
		.r               (r),
		.r_valid         (r_valid),
		.r_ready         (r_ready),
		.rd_req          (rd_req),
		.rd_cmd          (rd_cmd),
		.rd_grant        (rd_grant),
		.cmd_free        (cmd_free),
		.wr_pending      (wr_pending),
		.rdata_ren       (rdata_ren),
		.rdata_rdata     (rdata_rdata),
		.rdata_empty     (rdata_empty),
		.tran_inst_label (tran_inst_label)
	);

	qspi_cmd_arbiter i_qspi_cmd_arbiter (
		.clock     (clock),
		.rst_n     (rst_n),
		.wr_req    (wr_req),
		.wr_cmd    (wr_cmd),
		.wr_grant  (wr_grant),
		.rd_req    (rd_req),
		.rd_cmd    (rd_cmd),
		.rd_grant  (rd_grant),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_sent  (cmd_sent),
		.cmd_free  (cmd_free)
	);

endmodule

`default_nettype wire

// File: rtl/qspi_read_agent.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_read_agent (
	input  wire                                    clock,
	input  wire                                    rst_n,
	input  wire qspi_bridge_pkg::axi_addr_t        ar,
	input  wire                                    ar_valid,
	output logic                                   ar_ready,
	output qspi_bridge_pkg::axi_r_t                r,
	output logic                                   r_valid,
	input  wire                                    r_ready,
	output logic                                   rd_req,
	output qspi_bridge_pkg::flash_cmd_t            rd_cmd,
	input  wire                                    rd_grant,
	input  wire                                    cmd_free,
	input  wire                                    wr_pending,
	output logic                                   rdata_ren,
	input  wire [qspi_bridge_pkg::WORD_WIDTH-1:0]  rdata_rdata,
	input  wire                                    rdata_empty,
	input  wire                                    tran_inst_label
);

	qspi_bridge_pkg::rd_info_t info_in;
	qspi_bridge_pkg::rd_info_t head; // Oldest outstanding read
	logic info_full, info_empty;
	logic label_q;
	logic word_cnt;
	logic [qspi_bridge_pkg::BUS_WIDTH-1:0] data_q;
	logic [qspi_bridge_pkg::WORD_WIDTH-1:0] word;
	logic [7:0] beat_cnt;
	logic wide, pop_word, r_fire;

	assign ar_ready = ~info_full & ~wr_pending & cmd_free;
	assign rd_req   = ar_valid & ar_ready;
	assign rd_cmd   = qspi_bridge_pkg::make_cmd(qspi_bridge_pkg::INST_FRQIO, ar.addr,
		ar.len, ar.size);

	assign info_in.id   = ar.id;
	assign info_in.len  = ar.len;
	assign info_in.size = ar.size;

	qspi_read_info_fifo i_qspi_read_info_fifo (
		.clock (clock),
		.rst_n (rst_n),
		.push  (rd_grant),
		.din   (info_in),
		.pop   (r_fire & r.last),
		.dout  (head),
		.full  (info_full),
		.empty (info_empty)
	);

	assign wide      = head.size > 3'd2;
	assign r_fire    = r_valid & r_ready;
	assign pop_word  = ~rdata_empty & label_q & ~info_empty & ~r_valid; // Held beat blocks pops
	assign rdata_ren = pop_word;

	// Narrow beats land in the top word
	assign word = data_q[qspi_bridge_pkg::BUS_WIDTH-1 -: qspi_bridge_pkg::WORD_WIDTH];

	always_comb begin
		r.id   = head.id;
		r.resp = 2'b00;
		r.last = beat_cnt == head.len;
		case (head.size)
			3'd0:    r.data = {8{word[31:24]}};
			3'd1:    r.data = {4{word[31:16]}};
			3'd2:    r.data = {2{word}};
			default: r.data = data_q; // Second word above first
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			label_q  <= 1'b0;
			word_cnt <= 1'b0;
			r_valid  <= 1'b0;
			beat_cnt <= 8'd0;
		end else begin
			label_q <= tran_inst_label;
			if (pop_word) begin
				if (!wide || word_cnt) begin
					word_cnt <= 1'b0;
					r_valid  <= 1'b1;
				end else begin
					word_cnt <= 1'b1;
				end
			end else if (r_fire) begin
				r_valid <= 1'b0;
			end
			if (r_fire)
				beat_cnt <= r.last ? 8'd0 : beat_cnt + 8'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (pop_word)
			data_q <= {rdata_rdata, data_q[qspi_bridge_pkg::BUS_WIDTH-1:qspi_bridge_pkg::WORD_WIDTH]};
	end

endmodule

`default_nettype wire

// File: rtl/qspi_write_agent.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_write_agent (
	input  wire                                     clock,
	input  wire                                     rst_n,
	input  wire qspi_bridge_pkg::axi_addr_t         aw,
	input  wire                                     aw_valid,
	output logic                                    aw_ready,
	input  wire qspi_bridge_pkg::axi_w_t            w,
	input  wire                                     w_valid,
	output logic                                    w_ready,
	output qspi_bridge_pkg::axi_b_t                 b,
	output logic                                    b_valid,
	input  wire                                     b_ready,
	output logic                                    wr_req,
	output qspi_bridge_pkg::flash_cmd_t             wr_cmd,
	input  wire                                     wr_grant,
	input  wire                                     cmd_sent,
	output logic                                    wr_pending,
	output logic                                    tdata_wen,
	output logic [qspi_bridge_pkg::WORD_WIDTH-1:0]  tdata_wdata,
	input  wire                                     tdata_full,
	output logic                                    tdata_lock,
	output logic                                    tdata_key
);

	typedef enum logic [2:0] {S_IDLE, S_FIRST, S_REQ, S_PUSH, S_RESP} wr_state_t;

	wr_state_t state;
	qspi_bridge_pkg::axi_addr_t aw_q;
	logic [qspi_bridge_pkg::BUS_WIDTH-1:0] beat_q;
	logic [1:0] words_left; // Words still to push from beat_q
	logic beat_last_q;
	logic granted_q;
	logic aw_fire, w_fire, push;

	// Lowest set strobe index or 0 when none
	function automatic logic [2:0] low_strb(input logic [7:0] strb);
		logic [2:0] idx;
		idx = 3'd0;
		for (int i = 7; i >= 0; i--)
			if (strb[i])
				idx = 3'(i);
		return idx;
	endfunction

	function automatic logic [qspi_bridge_pkg::BUS_WIDTH-1:0] beat_data(
		input qspi_bridge_pkg::axi_w_t wb, input logic [2:0] size);
		logic [2:0] idx;
		logic [qspi_bridge_pkg::WORD_WIDTH-1:0] word;
		idx = low_strb(wb.strb);
		case (size)
			3'd0:    word = {4{wb.data[{idx, 3'b000} +: 8]}};
			3'd1:    word = {2{wb.data[{idx[2:1], 4'b0000} +: 16]}};
			default: word = wb.data[{idx[2], 5'b00000} +: 32];
		endcase
		if (size > 3'd2)
			return wb.data;
		return {{qspi_bridge_pkg::WORD_WIDTH{1'b0}}, word};
	endfunction

	assign aw_fire = aw_valid & aw_ready;
	assign w_fire  = w_valid & w_ready;

	assign aw_ready   = state == S_IDLE; // Held low until B is taken
	assign w_ready    = (state == S_FIRST) | ((state == S_PUSH) & (words_left == 2'd0));
	assign wr_req     = (state == S_REQ) & ~granted_q;
	assign wr_pending = aw_fire | wr_req;

	assign push        = (state == S_PUSH) & (words_left != 2'd0) & ~tdata_full;
	assign tdata_wen   = push;
	assign tdata_wdata = beat_q[qspi_bridge_pkg::WORD_WIDTH-1:0];
	assign tdata_lock  = (state == S_REQ) & granted_q & cmd_sent;
	assign tdata_key   = push & (words_left == 2'd1) & beat_last_q;

	assign b_valid = state == S_RESP;
	assign b.id    = aw_q.id;
	assign b.resp  = 2'b00; // Always OKAY

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state       <= S_IDLE;
			granted_q   <= 1'b0;
			words_left  <= 2'd0;
			beat_last_q <= 1'b0;
		end else begin
			case (state)
				S_IDLE:  if (aw_valid) state <= S_FIRST;
				S_FIRST: if (w_valid) state <= S_REQ;
				S_REQ:   if (granted_q & cmd_sent) state <= S_PUSH;
				S_PUSH:  if (tdata_key) state <= S_RESP;
				S_RESP:  if (b_ready) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
			if (wr_grant)
				granted_q <= 1'b1;
			else if (tdata_lock)
				granted_q <= 1'b0;
			if (w_fire) begin
				words_left  <= (aw_q.size > 3'd2) ? 2'(qspi_bridge_pkg::WORDS_PER_BEAT) : 2'd1;
				beat_last_q <= w.last;
			end else if (push) begin
				words_left <= words_left - 2'd1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire)
			aw_q <= aw;
		if (w_fire)
			beat_q <= beat_data(w, aw_q.size);
		else if (push)
			beat_q <= beat_q >> qspi_bridge_pkg::WORD_WIDTH; // Low word first
		// Address low bits from the first beat's strobes
		if (w_fire && state == S_FIRST)
			wr_cmd <= qspi_bridge_pkg::make_cmd(qspi_bridge_pkg::INST_PP,
				{aw_q.addr[qspi_bridge_pkg::FLASH_AWIDTH-1:3], low_strb(w.strb)},
				aw_q.len, aw_q.size);
	end

endmodule

`default_nettype wire

// File: rtl/qspi_cmd_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_cmd_arbiter (
	input  wire                               clock,
	input  wire                               rst_n,
	input  wire                               wr_req,
	input  wire qspi_bridge_pkg::flash_cmd_t  wr_cmd,
	output logic                              wr_grant,
	input  wire                               rd_req,
	input  wire qspi_bridge_pkg::flash_cmd_t  rd_cmd,
	output logic                              rd_grant,
	output qspi_bridge_pkg::flash_cmd_t       cmd,
	output logic                              cmd_valid,
	input  wire                               cmd_ready,
	output logic                              cmd_sent,
	output logic                              cmd_free
);

	assign cmd_free = ~cmd_valid;
	assign cmd_sent = cmd_valid & cmd_ready;

	// Writes win
	assign wr_grant = cmd_free & wr_req;
	assign rd_grant = cmd_free & rd_req & ~wr_req;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			cmd_valid <= 1'b0;
		else if (wr_grant | rd_grant)
			cmd_valid <= 1'b1;
		else if (cmd_sent)
			cmd_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (wr_grant)
			cmd <= wr_cmd;
		else if (rd_grant)
			cmd <= rd_cmd;
	end

endmodule

`default_nettype wire

// File: rtl/qspi_read_info_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_read_info_fifo (
	input  wire                             clock,
	input  wire                             rst_n,
	input  wire                             push,
	input  wire qspi_bridge_pkg::rd_info_t  din,
	input  wire                             pop,
	output qspi_bridge_pkg::rd_info_t       dout,
	output logic                            full,
	output logic                            empty
);

	qspi_bridge_pkg::rd_info_t mem [qspi_bridge_pkg::RD_INFO_DEPTH];
	logic [qspi_bridge_pkg::RD_INFO_AW-1:0] wr_ptr, rd_ptr; // Wrap naturally
	logic [qspi_bridge_pkg::RD_INFO_AW:0] count;
	logic do_push, do_pop;

	assign full    = count == (qspi_bridge_pkg::RD_INFO_AW + 1)'(qspi_bridge_pkg::RD_INFO_DEPTH);
	assign empty   = count == '0;
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;
	assign dout    = mem[rd_ptr]; // Head visible without latency

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

endmodule

`default_nettype wire

// File: rtl/qspi_bridge_pkg.sv
`default_nettype none

package qspi_bridge_pkg;

	localparam int BUS_WIDTH      = 64;
	localparam int WORD_WIDTH     = 32;
	localparam int WORDS_PER_BEAT = BUS_WIDTH / WORD_WIDTH;
	localparam int FLASH_AWIDTH   = 24;
	localparam int AXI_IDW        = 4;
	localparam int RD_INFO_DEPTH  = 4;
	localparam int RD_INFO_AW     = $clog2(RD_INFO_DEPTH);

	localparam logic [7:0] INST_PP    = 8'h02; // Page program
	localparam logic [7:0] INST_FRQIO = 8'hEB; // Fast read quad IO

	// Shared by AW and AR
	typedef struct packed {
		logic [AXI_IDW-1:0]      id;
		logic [FLASH_AWIDTH-1:0] addr;
		logic [7:0]              len;
		logic [2:0]              size;
	} axi_addr_t;

	typedef struct packed {
		logic [BUS_WIDTH-1:0]   data;
		logic [BUS_WIDTH/8-1:0] strb;
		logic                   last;
	} axi_w_t;

	typedef struct packed {
		logic [AXI_IDW-1:0] id;
		logic [1:0]         resp;
	} axi_b_t;

	typedef struct packed {
		logic [AXI_IDW-1:0]   id;
		logic [BUS_WIDTH-1:0] data;
		logic [1:0]           resp;
		logic                 last;
	} axi_r_t;

	typedef struct packed {
		logic [7:0]              inst;
		logic [FLASH_AWIDTH-1:0] addr;
		logic [7:0]              data_size; // Half-bytes per unit
		logic [7:0]              burstlen;  // Words
	} flash_cmd_t;

	typedef struct packed {
		logic [AXI_IDW-1:0] id;
		logic [7:0]         len;
		logic [2:0]         size;
	} rd_info_t;

	// Sizing rule common to page program and quad read
	function automatic flash_cmd_t make_cmd(input logic [7:0] inst,
		input logic [FLASH_AWIDTH-1:0] addr, input logic [7:0] len, input logic [2:0] size);
		flash_cmd_t c;
		c.inst = inst;
		c.addr = addr;
		case (size)
			3'd0:    c.data_size = 8'd2;
			3'd1:    c.data_size = 8'd4;
			default: c.data_size = 8'd8;
		endcase
		if (len == 8'd0)
			c.burstlen = (size > 3'd2) ? 8'(WORDS_PER_BEAT) : 8'd1;
		else
			c.burstlen = 8'((len + 8'd1) * WORDS_PER_BEAT); // Wraps past 127 beats
		return c;
	endfunction

endpackage

`default_nettype wire
